// ==== fpm_cfg.svh ====
`ifndef FPM_CFG_SVH
`define FPM_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// Register map
////////////////////////////////////////////////////////////////////////////

`define FPM_ADR_W       4            // Byte address bits on the bus

`define FPM_ADR_OP_A    4'h0         // Operand A, write only
`define FPM_ADR_OP_B    4'h4         // Operand B, write launches a multiply
`define FPM_ADR_RESULT  4'h8         // Last product
`define FPM_ADR_STATUS  4'hc         // Busy and sticky flags, write clears flags

////////////////////////////////////////////////////////////////////////////
// Number format
////////////////////////////////////////////////////////////////////////////

`define FPM_EXP_BIAS    127          // Single precision exponent bias

`endif

// ==== fpm_pkg.sv ====
`default_nettype none

`include "fpm_cfg.svh"

package fpm_pkg;

  typedef struct packed {
    logic        sign;
    logic [7:0]  exponent;
    logic [22:0] mantissa;
  } fp32_t;

  typedef enum logic [2:0] {
    cls_zero      = 3'b000,
    cls_subnormal = 3'b001,
    cls_inf       = 3'b010,
    cls_nan       = 3'b011,
    cls_normal    = 3'b100
  } fp_class_e;

  typedef struct packed {
    logic invalid;
    logic overflow;
    logic underflow;
    logic inexact;
  } fp_flags_t;                      // Order matches STATUS bits 4:1

  typedef struct packed {
    fp32_t a;
    fp32_t b;
  } mul_req_t;

  typedef struct packed {
    fp32_t     value;
    fp_flags_t flags;
  } path_out_t;

  typedef struct packed {
    fp32_t     result;
    fp_flags_t flags;
  } mul_rsp_t;

  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [`FPM_ADR_W-1:0] adr;
    logic [31:0]           dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

endpackage

`default_nettype wire

// ==== fpm_special_path.sv ====
`timescale 1ns/1ns
`default_nettype none

module fpm_special_path (
  input  logic               clk,
  input  logic               reset,
  input  logic               start,
  input  fpm_pkg::mul_req_t  req,
  output fpm_pkg::path_out_t special,
  output logic               hit,
  output logic               valid
);
  import fpm_pkg::*;

  function automatic fp_class_e classify(input fp32_t x);
    if (x.exponent == 8'h00) begin
      return (x.mantissa == '0) ? cls_zero : cls_subnormal;
    end
    if (x.exponent == 8'hff) begin
      return (x.mantissa == '0) ? cls_inf : cls_nan;
    end
    return cls_normal;
  endfunction

  fp_class_e cls_a;
  fp_class_e cls_b;
  logic      zero_any;                                 // Subnormal counts as zero
  logic      inf_any;
  logic      nan_any;
  logic      sign_out;
  logic      hit_nxt;
  path_out_t special_nxt;

  always_comb begin
    cls_a    = classify(req.a);
    cls_b    = classify(req.b);
    zero_any = (cls_a inside {cls_zero, cls_subnormal}) ||
               (cls_b inside {cls_zero, cls_subnormal});
    inf_any  = (cls_a == cls_inf) || (cls_b == cls_inf);
    nan_any  = (cls_a == cls_nan) || (cls_b == cls_nan);
    sign_out = req.a.sign ^ req.b.sign;
    hit_nxt  = zero_any || inf_any || nan_any;

    special_nxt = '0;
    if (nan_any || (zero_any && inf_any)) begin
      special_nxt.value         = 32'h7fc00000;       // Canonical quiet NaN
      special_nxt.flags.invalid = 1'b1;
    end else if (inf_any) begin
      special_nxt.value = {sign_out, 8'hff, 23'd0};   // Signed infinity
    end else if (zero_any) begin
      special_nxt.value = {sign_out, 8'h00, 23'd0};   // Signed zero
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= 1'b0;
    end else begin
      valid <= start;                                  // Stage valid for the merger
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      hit     <= hit_nxt;
      special <= special_nxt;
    end
  end

endmodule

`default_nettype wire

// ==== fpm_normal_path.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fpm_cfg.svh"

module fpm_normal_path (
  input  logic               clk,
  input  logic               reset,
  input  logic               start,
  input  fpm_pkg::mul_req_t  req,
  output fpm_pkg::path_out_t normal
);
  import fpm_pkg::*;

  logic               sign_out;
  logic [47:0]        prod;                            // 1.xx * 1.xx lands in [1,4)
  logic               norm_hi;
  logic [22:0]        mant_trunc;
  logic               guard;
  logic               sticky;
  logic               round_up;
  logic [23:0]        mant_rnd;                        // Bit 23 is the rounding carry
  logic signed [9:0]  exp_sum;
  logic signed [9:0]  exp_final;
  path_out_t          normal_nxt;

  ////////////////////////////////////////////////////////////////////////////
  // Significand product and normalization
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    sign_out = req.a.sign ^ req.b.sign;
    prod     = {1'b1, req.a.mantissa} * {1'b1, req.b.mantissa};
    norm_hi  = prod[47];                               // Product >= 2, shift by one

    if (norm_hi) begin
      mant_trunc = prod[46:24];
      guard      = prod[23];
      sticky     = |prod[22:0];
    end else begin
      mant_trunc = prod[45:23];
      guard      = prod[22];
      sticky     = |prod[21:0];
    end

    // Exponent in 10-bit two's complement so both range ends stay visible
    exp_sum = 10'(req.a.exponent) + 10'(req.b.exponent) + 10'(norm_hi)
              - 10'(`FPM_EXP_BIAS);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Round to nearest, ties to even
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    round_up  = guard & (sticky | mant_trunc[0]);
    mant_rnd  = {1'b0, mant_trunc} + 24'(round_up);
    exp_final = exp_sum + 10'(mant_rnd[23]);          // All ones rolls into exponent
  end

  ////////////////////////////////////////////////////////////////////////////
  // Exponent range check
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    normal_nxt = '0;
    if (exp_final >= 10'sd255) begin
      normal_nxt.value           = {sign_out, 8'hff, 23'd0};
      normal_nxt.flags.overflow  = 1'b1;
      normal_nxt.flags.inexact   = 1'b1;
    end else if (exp_final <= 10'sd0) begin
      normal_nxt.value           = {sign_out, 8'h00, 23'd0};  // Flush to zero
      normal_nxt.flags.underflow = 1'b1;
      normal_nxt.flags.inexact   = 1'b1;
    end else begin
      normal_nxt.value         = {sign_out, exp_final[7:0], mant_rnd[22:0]};
      normal_nxt.flags.inexact = guard | sticky;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      normal <= '0;
    end else if (start) begin
      normal <= normal_nxt;
    end
  end

endmodule

`default_nettype wire

// ==== fpm_result_merge.sv ====
`timescale 1ns/1ns
`default_nettype none

module fpm_result_merge (
  input  logic               clk,
  input  logic               reset,
  input  logic               hit,
  input  logic               valid,
  input  fpm_pkg::path_out_t special,
  input  fpm_pkg::path_out_t normal,
  output fpm_pkg::mul_rsp_t  rsp,
  output logic               done
);

  always_ff @(posedge clk) begin
    if (reset) begin
      done <= 1'b0;
    end else begin
      done <= valid;                                   // One pulse per item
    end
  end

  // Response holds until the next item arrives
  always_ff @(posedge clk) begin
    if (valid) begin
      if (hit) begin
        rsp.result <= special.value;
        rsp.flags  <= special.flags;
      end else begin
        rsp.result <= normal.value;
        rsp.flags  <= normal.flags;
      end
    end
  end

endmodule

`default_nettype wire

// ==== fpm_wb_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fpm_cfg.svh"

module fpm_wb_regs (
  input  logic              clk,
  input  logic              reset,
  input  fpm_pkg::wb_req_t  wb_req,
  output fpm_pkg::wb_rsp_t  wb_rsp,
  output fpm_pkg::mul_req_t req,
  output logic              start,
  input  fpm_pkg::mul_rsp_t rsp,
  input  logic              done
);
  import fpm_pkg::*;

  logic        strobe;                                 // New cycle, not yet acked
  logic        wr;
  logic        sel_op_a;
  logic        sel_op_b;
  logic        sel_status;
  logic        busy;
  fp_flags_t   sticky;
  fp32_t       result_q;
  logic [31:0] rd_data;

  ////////////////////////////////////////////////////////////////////////////
  // Bus decode
  ////////////////////////////////////////////////////////////////////////////

  assign strobe     = wb_req.cyc & wb_req.stb & ~wb_rsp.ack;
  assign wr         = strobe & wb_req.we;
  assign sel_op_a   = wb_req.adr == `FPM_ADR_OP_A;
  assign sel_op_b   = wb_req.adr == `FPM_ADR_OP_B;
  assign sel_status = wb_req.adr == `FPM_ADR_STATUS;

  always_comb begin
    case (wb_req.adr)
      `FPM_ADR_RESULT: rd_data = result_q;
      `FPM_ADR_STATUS: rd_data = {27'd0, sticky, busy};
      default:         rd_data = '0;                   // Operands read back as zero
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Control and status
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_rsp   <= '0;
      start    <= 1'b0;
      busy     <= 1'b0;
      sticky   <= '0;
      result_q <= '0;
    end else begin
      wb_rsp.ack <= strobe;
      if (strobe && !wb_req.we) begin
        wb_rsp.dat <= rd_data;
      end
      start <= wr & sel_op_b;                          // Fires with the OP_B ack
      if (wr && sel_op_b) begin
        busy <= 1'b1;
      end else if (done) begin
        busy <= 1'b0;
      end
      if (wr && sel_status) begin
        sticky <= '0;
      end else if (done) begin
        sticky <= sticky | rsp.flags;
      end
      if (done) begin
        result_q <= rsp.result;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr && sel_op_a) begin
      req.a <= wb_req.dat;
    end
    if (wr && sel_op_b) begin
      req.b <= wb_req.dat;
    end
  end

endmodule

`default_nettype wire

// ==== fpm_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module fpm_top (
  input  logic             clk,
  input  logic             reset,
  input  fpm_pkg::wb_req_t wb_req,
  output fpm_pkg::wb_rsp_t wb_rsp
);
  import fpm_pkg::*;

  mul_req_t  req;
  logic      start;
  path_out_t special;
  path_out_t normal;
  logic      hit;
  logic      valid;
  mul_rsp_t  rsp;
  logic      done;

  fpm_wb_regs i_regs (
    .clk    (clk),
    .reset  (reset),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp),
    .req    (req),
    .start  (start),
    .rsp    (rsp),
    .done   (done)
  );

  fpm_special_path i_special (
    .clk     (clk),
    .reset   (reset),
    .start   (start),
    .req     (req),
    .special (special),
    .hit     (hit),
    .valid   (valid)
  );

  fpm_normal_path i_normal (
    .clk    (clk),
    .reset  (reset),
    .start  (start),
    .req    (req),
    .normal (normal)
  );

  fpm_result_merge i_merge (
    .clk     (clk),
    .reset   (reset),
    .hit     (hit),
    .valid   (valid),
    .special (special),
    .normal  (normal),
    .rsp     (rsp),
    .done    (done)
  );

endmodule

`default_nettype wire

// ==== fpm_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fpm_cfg.svh"

module fpm_tb;
  import fpm_pkg::*;

  localparam int ACK_LIMIT  = 20;                      // Cycles to wait for ack
  localparam int POLL_LIMIT = 20;                      // STATUS reads to wait for idle

  logic        clk;
  logic        reset;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  logic [31:0] lfsr_state;
  fp_flags_t   sticky_model;                           // OR of expected flags since clear

  // Directed special cases with expected values worked out by hand
  logic [31:0] dir_a [11] = '{32'h00000000, 32'h7f800000, 32'h7fa00000, 32'h40000000,
                              32'h7f800000, 32'h80000000, 32'h00012345, 32'h80000001,
                              32'h3fc00000, 32'h7f000000, 32'h00800000};
  logic [31:0] dir_b [11] = '{32'h7f800000, 32'h80000000, 32'h3f800000, 32'hffc00001,
                              32'hc0000000, 32'h40400000, 32'h40a00000, 32'hff800000,
                              32'h3fc00000, 32'h7f000000, 32'h00800000};
  logic [31:0] dir_r [11] = '{32'h7fc00000, 32'h7fc00000, 32'h7fc00000, 32'h7fc00000,
                              32'hff800000, 32'h80000000, 32'h00000000, 32'h7fc00000,
                              32'h40100000, 32'h7f800000, 32'h00000000};
  logic [3:0]  dir_f [11] = '{4'b1000, 4'b1000, 4'b1000, 4'b1000, 4'b0000, 4'b0000,
                              4'b0000, 4'b1000, 4'b0000, 4'b0101, 4'b0011};

  fpm_top i_dut (
    .clk    (clk),
    .reset  (reset),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
  );

  always #2 clk = ~clk;

  task automatic stop_run();
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic check_equal(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("FAILED time %0t: %s expected %h actual %h", $time, name, expected, actual);
      stop_run();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Random source
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];                  // x^32 + x^22 + x^2 + x + 1
    return {s[30:0], fb};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] val);
    int i;
    val = '0;
    for (i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val        = {val[30:0], lfsr_state[0]};
    end
  endtask

  task automatic make_normal(input int base, input int span_bits, output fp32_t x);
    logic [31:0] bits;
    draw_bits(1, bits);
    x.sign = bits[0];
    draw_bits(span_bits, bits);
    x.exponent = 8'(base + int'(bits));
    draw_bits(23, bits);
    x.mantissa = bits[22:0];
  endtask

  task automatic make_special(output fp32_t x);
    logic [31:0] kind;
    logic [31:0] bits;
    draw_bits(2, kind);
    draw_bits(24, bits);
    x.sign     = bits[23];
    x.exponent = kind[1] ? 8'hff : 8'h00;
    x.mantissa = kind[0] ? (bits[22:0] | 23'd1) : 23'd0;  // Subnormal or NaN when set
  endtask

  // Exponent sums close to the overflow or underflow limit
  task automatic make_limit_pair(input logic high, output fp32_t a, output fp32_t b);
    logic [31:0] bits;
    make_normal(high ? 192 : 1, high ? 5 : 6, a);
    make_normal(0, 0, b);
    draw_bits(2, bits);
    b.exponent = 8'((high ? 381 : 126) - int'(a.exponent) + int'(bits));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic mul_rsp_t model_mul(input fp32_t a, input fp32_t b);
    mul_rsp_t    r;
    logic        sign;
    logic        zero;
    logic        inf;
    logic        nan;
    logic [63:0] prod;
    logic [63:0] quot;
    logic [63:0] rem;
    logic [63:0] half;
    int          shift;
    int          e;
    r    = '0;
    sign = a.sign ^ b.sign;
    zero = (a.exponent == 8'h00) || (b.exponent == 8'h00);   // Subnormal reads as zero
    inf  = (a.exponent == 8'hff && a.mantissa == 0) || (b.exponent == 8'hff && b.mantissa == 0);
    nan  = (a.exponent == 8'hff && a.mantissa != 0) || (b.exponent == 8'hff && b.mantissa != 0);
    if (nan || (zero && inf)) begin
      r.result        = 32'h7fc00000;
      r.flags.invalid = 1'b1;
      return r;
    end
    if (inf || zero) begin
      r.result = {sign, inf ? 8'hff : 8'h00, 23'd0};
      return r;
    end
    prod  = {40'd0, 1'b1, a.mantissa} * {40'd0, 1'b1, b.mantissa};
    e     = int'(a.exponent) + int'(b.exponent) - `FPM_EXP_BIAS;
    shift = (prod >= (64'd1 << 47)) ? 24 : 23;
    e     = e + shift - 23;
    quot  = prod >> shift;
    rem   = prod & ((64'd1 << shift) - 1);
    half  = 64'd1 << (shift - 1);
    if (rem > half || (rem == half && quot[0])) begin  // Ties to even
      quot = quot + 1;
    end
    if (quot == (64'd1 << 24)) begin
      quot = quot >> 1;
      e    = e + 1;
    end
    if (e >= 255) begin
      r.result         = {sign, 8'hff, 23'd0};
      r.flags.overflow = 1'b1;
      r.flags.inexact  = 1'b1;
    end else if (e <= 0) begin
      r.result          = {sign, 31'd0};
      r.flags.underflow = 1'b1;
      r.flags.inexact   = 1'b1;
    end else begin
      r.result        = {sign, 8'(e), quot[22:0]};
      r.flags.inexact = (rem != 0);
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Bus access and operations
  ////////////////////////////////////////////////////////////////////////////

  task automatic bus_cycle(input logic we, input logic [3:0] adr, input logic [31:0] wdat,
                           output logic [31:0] rdat);
    int waited;
    @(negedge clk);
    assert (!wb_rsp.ack) else begin                    // Ack lasts a single cycle
      $display("Ack still high before a new bus cycle to address %h", adr);
      stop_run();
    end
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
    waited = 0;
    @(negedge clk);
    while (!wb_rsp.ack && waited < ACK_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    assert (wb_rsp.ack) else begin
      $display("No ack from the slave for address %h within %0d cycles", adr, ACK_LIMIT);
      stop_run();
    end
    rdat   = wb_rsp.dat;
    wb_req = '0;                                       // Drop strobe after the ack
  endtask

  task automatic write_reg(input logic [3:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    bus_cycle(1'b1, adr, data, unused);
  endtask

  task automatic read_reg(input logic [3:0] adr, output logic [31:0] data);
    bus_cycle(1'b0, adr, '0, data);
  endtask

  task automatic clear_flags();
    logic [31:0] status;
    write_reg(`FPM_ADR_STATUS, 32'd0);
    sticky_model = '0;
    read_reg(`FPM_ADR_STATUS, status);
    check_equal("STATUS after clear", 32'd0, status);
  endtask

  task automatic run_op(input fp32_t a, input fp32_t b, output logic [31:0] result,
                        output logic [31:0] status);
    mul_rsp_t expected;
    int       polls;
    expected = model_mul(a, b);
    write_reg(`FPM_ADR_OP_A, a);
    write_reg(`FPM_ADR_OP_B, b);
    read_reg(`FPM_ADR_STATUS, status);                 // Busy or already finished
    if (status[0]) begin
      check_equal("STATUS busy", {27'd0, sticky_model, 1'b1}, status);
    end else begin
      check_equal("STATUS early", {27'd0, sticky_model | expected.flags, 1'b0}, status);
    end
    polls = 0;
    while (status[0] && polls < POLL_LIMIT) begin
      read_reg(`FPM_ADR_STATUS, status);
      polls++;
    end
    assert (!status[0]) else begin
      $display("Busy still set after %0d STATUS reads", POLL_LIMIT);
      stop_run();
    end
    sticky_model = sticky_model | expected.flags;
    read_reg(`FPM_ADR_RESULT, result);
    check_equal("RESULT", expected.result, result);
    check_equal("STATUS", {27'd0, sticky_model, 1'b0}, status);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    fp32_t       a;
    fp32_t       b;
    logic [31:0] bits;
    logic [31:0] result;
    logic [31:0] status;
    int          i;
    clk          = 1'b0;
    reset        = 1'b1;
    wb_req       = '0;
    lfsr_state   = 32'hdad6;
    sticky_model = '0;
    repeat (3) @(negedge clk);
    reset = 1'b0;

    read_reg(`FPM_ADR_STATUS, status);
    check_equal("STATUS after reset", 32'd0, status);
    read_reg(`FPM_ADR_RESULT, result);
    check_equal("RESULT after reset", 32'd0, result);

    for (i = 0; i < 300; i++) begin                    // Exponents kept mostly in range
      make_normal(64, 7, a);
      make_normal(64, 7, b);
      run_op(a, b, result, status);
    end

    for (i = 0; i < 11; i++) begin
      clear_flags();
      run_op(dir_a[i], dir_b[i], result, status);
      check_equal("RESULT directed", dir_r[i], result);
      check_equal("STATUS directed", {27'd0, dir_f[i], 1'b0}, status);
    end

    clear_flags();
    for (i = 0; i < 60; i++) begin
      draw_bits(2, bits);
      make_special(a);
      if (bits[0]) make_special(b);
      else make_normal(1, 7, b);
      if (bits[1]) run_op(b, a, result, status);
      else run_op(a, b, result, status);
    end

    clear_flags();
    for (i = 0; i < 60; i++) begin
      draw_bits(1, bits);
      make_limit_pair(bits[0], a, b);
      run_op(a, b, result, status);
    end

    read_reg(`FPM_ADR_OP_A, result);                   // Write-only register
    check_equal("OP_A readback", 32'd0, result);
    clear_flags();

    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
fpm_pkg.sv
fpm_special_path.sv
fpm_normal_path.sv
fpm_result_merge.sv
fpm_wb_regs.sv
fpm_top.sv
fpm_tb.sv

// ==== Bender.yml ====
package:
  name: fpm

export_include_dirs:
  - .

sources:
  - files:
      - fpm_pkg.sv
      - fpm_special_path.sv
      - fpm_normal_path.sv
      - fpm_result_merge.sv
      - fpm_wb_regs.sv
      - fpm_top.sv
  - target: test
    files:
      - fpm_tb.sv
